//--- source/bus_pkg.sv
// System bus package
// Bus address and data types, RAM word index
// Address map of the work RAM banks and the INPUTCTRL window

package bus_pkg;

	////////////////////
	// Widths
	////////////////////

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	localparam int RAM_DEPTH = 2048;                  // Words per bank
	localparam int RAM_ADDR_W = $clog2(RAM_DEPTH);

	typedef logic [ADDR_W-1:0]     addr_t;
	typedef logic [DATA_W-1:0]     data_t;
	typedef logic [RAM_ADDR_W-1:0] ram_addr_t;

	////////////////////
	// Address map
	////////////////////

	// INPUTCTRL sits in the low TIA window, write only
	localparam addr_t CTRL_BASE = 16'h0000;
	localparam int    CTRL_SPAN = 32;

	localparam addr_t RAM0_BASE = 16'h1800;
	localparam addr_t RAM1_BASE = 16'h2000;

endpackage

//--- source/ctrl_pkg.sv
// Control package
// INPUTCTRL bit positions and write count type
// State encodings for arbiter, clear engine and decoder

package ctrl_pkg;

	// INPUTCTRL data bits
	localparam int CTRL_LOCK     = 0;
	localparam int CTRL_MARIA_EN = 1;
	localparam int CTRL_BIOS_EN  = 2;
	localparam int CTRL_TIA_EN   = 3;

	typedef logic [1:0] write_count_t;
	localparam write_count_t WRITES_FULL = 2'd2;   // Halt allowed from here

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_HOST,
		ARB_CLEAR,
		ARB_RELEASE
	} arb_state_t;

	typedef enum logic [1:0] {CLR_IDLE, CLR_REQ, CLR_WAIT_LOW} clear_state_t;

	typedef enum logic {SLV_IDLE, SLV_ACK} slave_state_t;

endpackage

//--- source/mem_bus_if.sv
// Four-phase memory bus
// req/ack handshake with address, write enable and data

`timescale 1ns/1ps

interface mem_bus_if;

	logic           req;
	logic           ack;
	bus_pkg::addr_t addr;
	logic           we;
	bus_pkg::data_t wdata;
	bus_pkg::data_t rdata;     // Valid while ack is high

	modport master (
		output req, addr, we, wdata,
		input  ack, rdata
	);

	modport slave (
		input  req, addr, we, wdata,
		output ack, rdata
	);

endinterface

//--- source/work_ram.sv
// Work RAM bank
// 2 KB single port, synchronous write, registered read

`timescale 1ns/1ps

module work_ram
	import bus_pkg::*;
(
	input  logic      clk_sys,
	input  ram_addr_t addr,
	input  logic      we,
	input  data_t     wdata,
	output data_t     rdata
);

	data_t mem [RAM_DEPTH];

	always_ff @(posedge clk_sys) begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];   // Old data on a write cycle
	end

endmodule

//--- source/inputctrl_reg.sv
// INPUTCTRL register
// Lock bit, MARIA/BIOS/TIA enables, saturating write count
// BIOS bypass preset on the first cycle out of reset

`timescale 1ns/1ps

module inputctrl_reg
	import bus_pkg::*;
	import ctrl_pkg::*;
(
	input  logic  clk_sys,
	input  logic  reset,
	input  logic  wr,
	input  data_t wdata,
	input  logic  bypass_bios,
	input  logic  tia_mode,
	output logic  maria_en,
	output logic  bios_en,
	output logic  tia_en,
	output logic  locked,
	output logic  halt_enable
);

	write_count_t writes;
	logic first;          // First cycle after reset

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			maria_en <= 1'b0;
			bios_en <= 1'b0;
			tia_en <= 1'b0;
			locked <= 1'b0;
			writes <= '0;
			first <= 1'b1;
		end else begin
			first <= 1'b0;
			if (first && bypass_bios) begin
				// Skip the BIOS, pick the console mode directly
				maria_en <= ~tia_mode;
				bios_en <= 1'b1;
				tia_en <= tia_mode;
				locked <= tia_mode;
				writes <= WRITES_FULL;
			end else if (wr && !locked) begin
				locked <= wdata[CTRL_LOCK];
				maria_en <= wdata[CTRL_MARIA_EN];
				bios_en <= wdata[CTRL_BIOS_EN];
				tia_en <= wdata[CTRL_TIA_EN];
				if (writes != WRITES_FULL)
					writes <= writes + 1'b1;
			end
		end
	end

	assign halt_enable = (writes == WRITES_FULL);

endmodule

//--- source/bus_decoder.sv
// Bus slave
// Region decode for RAM0, RAM1 and INPUTCTRL
// Four-phase responder and open bus tracking

`timescale 1ns/1ps

module bus_decoder
	import bus_pkg::*;
	import ctrl_pkg::*;
(
	input  logic clk_sys,
	input  logic reset,
	mem_bus_if.slave bus,
	input  logic bypass_bios,
	input  logic tia_mode,
	output logic maria_en,
	output logic bios_en,
	output logic tia_en,
	output logic locked,
	output logic halt_enable
);

	slave_state_t state;
	logic      pend;         // Request seen, RAM read in flight
	logic      wr_strobe;
	logic      sel_ctrl, sel_ram0, sel_ram1;
	addr_t     ctrl_off, ram0_off, ram1_off;
	ram_addr_t ram_addr;
	data_t     ram0_q, ram1_q;
	data_t     read_mux;
	data_t     open_bus;

	////////////////////
	// Decode
	////////////////////

	assign ctrl_off = bus.addr - CTRL_BASE;
	assign ram0_off = bus.addr - RAM0_BASE;
	assign ram1_off = bus.addr - RAM1_BASE;

	assign sel_ctrl = ctrl_off < CTRL_SPAN;
	assign sel_ram0 = ram0_off < RAM_DEPTH;
	assign sel_ram1 = ram1_off < RAM_DEPTH;

	assign ram_addr = ram_addr_t'(bus.addr);
	assign wr_strobe = (state == SLV_IDLE) && pend && bus.we;   // One per transaction

	always_comb begin
		read_mux = open_bus;      // Unmapped and INPUTCTRL
		if (sel_ram0)
			read_mux = ram0_q;
		else if (sel_ram1)
			read_mux = ram1_q;
	end

	work_ram ram0 (
		.clk_sys (clk_sys),
		.addr    (ram_addr),
		.we      (wr_strobe && sel_ram0),
		.wdata   (bus.wdata),
		.rdata   (ram0_q)
	);

	work_ram ram1 (
		.clk_sys (clk_sys),
		.addr    (ram_addr),
		.we      (wr_strobe && sel_ram1),
		.wdata   (bus.wdata),
		.rdata   (ram1_q)
	);

	inputctrl_reg ctrl (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.wr          (wr_strobe && sel_ctrl),
		.wdata       (bus.wdata),
		.bypass_bios (bypass_bios),
		.tia_mode    (tia_mode),
		.maria_en    (maria_en),
		.bios_en     (bios_en),
		.tia_en      (tia_en),
		.locked      (locked),
		.halt_enable (halt_enable)
	);

	////////////////////
	// Handshake
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= SLV_IDLE;
			pend <= 1'b0;
			bus.ack <= 1'b0;
			open_bus <= '0;
		end else begin
			case (state)
				SLV_IDLE: begin
					if (pend) begin
						pend <= 1'b0;
						bus.ack <= 1'b1;
						state <= SLV_ACK;
						open_bus <= bus.we ? bus.wdata : read_mux;
					end else if (bus.req) begin
						pend <= 1'b1;
					end
				end
				SLV_ACK: begin
					if (!bus.req) begin
						bus.ack <= 1'b0;
						state <= SLV_IDLE;
					end
				end
				default: state <= SLV_IDLE;
			endcase
		end
	end

	// Read data goes out with ack
	always_ff @(posedge clk_sys) begin
		if (state == SLV_IDLE && pend)
			bus.rdata <= read_mux;
	end

endmodule

//--- source/ram_clear.sv
// RAM clear engine
// Fills both work RAM banks with a fill value on a rising loading edge

`timescale 1ns/1ps

module ram_clear
	import bus_pkg::*;
	import ctrl_pkg::*;
(
	input  logic  clk_sys,
	input  logic  reset,
	input  logic  loading,
	input  data_t clearval,
	output logic  clear_busy,
	mem_bus_if.master bus
);

	clear_state_t state;
	logic        loading_d;
	logic        start;
	logic [11:0] count;        // Bit 11 picks the bank
	ram_addr_t   word;
	data_t       fill;

	assign start = (state == CLR_IDLE) && loading && !loading_d;
	assign word = ram_addr_t'(count);

	assign bus.addr = count[11] ? RAM1_BASE + addr_t'(word) : RAM0_BASE + addr_t'(word);
	assign bus.we = 1'b1;
	assign bus.wdata = fill;

	always_ff @(posedge clk_sys) begin
		if (start)
			fill <= clearval;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= CLR_IDLE;
			loading_d <= 1'b0;
			count <= '0;
			bus.req <= 1'b0;
			clear_busy <= 1'b0;
		end else begin
			loading_d <= loading;
			case (state)
				CLR_IDLE: begin
					if (start) begin
						count <= '0;
						bus.req <= 1'b1;
						clear_busy <= 1'b1;
						state <= CLR_REQ;
					end
				end
				CLR_REQ: begin
					if (bus.ack) begin
						bus.req <= 1'b0;
						state <= CLR_WAIT_LOW;
					end
				end
				CLR_WAIT_LOW: begin
					if (!bus.ack) begin
						if (count == '1) begin   // Last word of RAM1
							clear_busy <= 1'b0;
							state <= CLR_IDLE;
						end else begin
							count <= count + 1'b1;
							bus.req <= 1'b1;
							state <= CLR_REQ;
						end
					end
				end
				default: state <= CLR_IDLE;
			endcase
		end
	end

endmodule

//--- source/bus_arbiter.sv
// Bus arbiter
// Two masters onto one bus, clear engine has priority
// One registered stage on every handshake edge

`timescale 1ns/1ps

module bus_arbiter
	import bus_pkg::*;
	import ctrl_pkg::*;
(
	input  logic clk_sys,
	input  logic reset,
	mem_bus_if.slave  host,
	mem_bus_if.slave  clear,
	mem_bus_if.master mem
);

	arb_state_t state;

	// Request fields follow the grant
	always_comb begin
		if (state == ARB_CLEAR) begin
			mem.addr = clear.addr;
			mem.we = clear.we;
			mem.wdata = clear.wdata;
		end else begin
			mem.addr = host.addr;
			mem.we = host.we;
			mem.wdata = host.wdata;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= ARB_IDLE;
			mem.req <= 1'b0;
			host.ack <= 1'b0;
			clear.ack <= 1'b0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (clear.req) begin
						mem.req <= 1'b1;
						state <= ARB_CLEAR;
					end else if (host.req) begin
						mem.req <= 1'b1;
						state <= ARB_HOST;
					end
				end
				ARB_HOST: begin
					mem.req <= host.req;
					host.ack <= mem.ack;
					if (host.ack && !mem.ack)   // Downstream ack has fallen
						state <= ARB_RELEASE;
				end
				ARB_CLEAR: begin
					mem.req <= clear.req;
					clear.ack <= mem.ack;
					if (clear.ack && !mem.ack)
						state <= ARB_RELEASE;
				end
				// Gap so the clear engine can re-request before the host is seen
				ARB_RELEASE: state <= ARB_IDLE;
				default: state <= ARB_IDLE;
			endcase
		end
	end

	// Read data only to the granted master
	always_ff @(posedge clk_sys) begin
		if (state == ARB_HOST && mem.ack && !host.ack)
			host.rdata <= mem.rdata;
		if (state == ARB_CLEAR && mem.ack && !clear.ack)
			clear.rdata <= mem.rdata;
	end

endmodule

//--- source/console_bus.sv
// Console memory subsystem top level
// Host port, RAM clear engine, arbiter and bus decoder

`timescale 1ns/1ps

module console_bus
	import bus_pkg::*;
(
	input  logic  clk_sys,
	input  logic  reset,
	input  logic  req,
	input  addr_t addr,
	input  logic  we,
	input  data_t wdata,
	input  logic  loading,
	input  data_t clearval,
	input  logic  bypass_bios,
	input  logic  tia_mode,
	output logic  ack,
	output data_t rdata,
	output logic  clear_busy,
	output logic  maria_en,
	output logic  bios_en,
	output logic  tia_en,
	output logic  locked,
	output logic  halt_enable
);

	mem_bus_if host_bus ();
	mem_bus_if clear_bus ();
	mem_bus_if mem_bus ();

	// Host side of the shared bus
	assign host_bus.req = req;
	assign host_bus.addr = addr;
	assign host_bus.we = we;
	assign host_bus.wdata = wdata;
	assign ack = host_bus.ack;
	assign rdata = host_bus.rdata;

	ram_clear clr (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.loading    (loading),
		.clearval   (clearval),
		.clear_busy (clear_busy),
		.bus        (clear_bus.master)
	);

	bus_arbiter arb (
		.clk_sys (clk_sys),
		.reset   (reset),
		.host    (host_bus.slave),
		.clear   (clear_bus.slave),
		.mem     (mem_bus.master)
	);

	bus_decoder dec (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.bus         (mem_bus.slave),
		.bypass_bios (bypass_bios),
		.tia_mode    (tia_mode),
		.maria_en    (maria_en),
		.bios_en     (bios_en),
		.tia_en      (tia_en),
		.locked      (locked),
		.halt_enable (halt_enable)
	);

endmodule

//--- bench/console_bus_assert.sv
// Handshake assertions for the console bus top level
// Host port req/ack ordering and reset state

`timescale 1ns/1ps

module console_bus_assert (
	input logic clk_sys,
	input logic reset,
	input logic req,
	input logic ack,
	input logic clear_busy
);

	int fail_count = 0;   // Read by the testbench at the end

	ack_needs_req: assert property (
		@(posedge clk_sys) disable iff (reset)
		$rose(ack) |-> req
	) else begin
		fail_count++;
		$error("host ack rose without a pending req");
	end

	// Master holds its request until answered
	req_held: assert property (
		@(posedge clk_sys) disable iff (reset)
		req && !ack |=> req
	) else begin
		fail_count++;
		$error("host req dropped before ack");
	end

	quiet_in_reset: assert property (
		@(posedge clk_sys)
		reset && $past(reset) |-> !ack && !clear_busy
	) else begin
		fail_count++;
		$error("ack or clear_busy high during reset");
	end

endmodule

bind console_bus console_bus_assert handshake_chk (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.req        (req),
	.ack        (ack),
	.clear_busy (clear_busy)
);

//--- bench/tb_console_bus.sv
// Testbench for the console memory subsystem
// Host handshake task, LFSR stimulus, reference model, comparison process
// RAM readback, open bus, INPUTCTRL, RAM clear and BIOS bypass

`timescale 1ns/1ps

module tb_console_bus
	import bus_pkg::*;
	import ctrl_pkg::*;
();

	logic  clk_sys = 1'b0;
	logic  reset, req, we, loading, bypass_bios, tia_mode;
	addr_t addr;
	data_t wdata, clearval, rdata;
	logic  ack, clear_busy, maria_en, bios_en, tia_en, locked, halt_enable;
	logic [4:0] flags_dut;

	// Reference state
	data_t ram0_m [RAM_DEPTH];
	data_t ram1_m [RAM_DEPTH];
	data_t open_m;
	logic [4:0] flags_m;       // maria, bios, tia, locked, halt
	int writes_m;

	data_t exp_rd;
	logic [4:0] exp_flags;
	logic  chk_read;
	string chk_name;
	logic  ack_d = 1'b0;
	logic  timed_out = 1'b0;
	int checks = 0;
	int errors = 0;
	logic [31:0] lfsr = 32'h738af15b;

	always #2 clk_sys = ~clk_sys;

	assign flags_dut = {maria_en, bios_en, tia_en, locked, halt_enable};

	console_bus DUT (.*);

	////////////////////
	// Helpers
	////////////////////

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		logic b;
		v = '0;
		for (int i = 0; i < n; i++) begin
			b = lfsr[0];
			lfsr = lfsr >> 1;
			if (b)
				lfsr = lfsr ^ 32'hA3000000;
			v = {v[30:0], b};
		end
		return v;
	endfunction

	// Updates the model and returns the expected read data
	function automatic data_t model_access(addr_t a, logic w, data_t d);
		int ai;
		data_t r;
		ai = int'(a);
		r = open_m;
		if (ai >= int'(RAM0_BASE) && ai < int'(RAM0_BASE) + RAM_DEPTH) begin
			if (w)
				ram0_m[ram_addr_t'(a - RAM0_BASE)] = d;
			r = ram0_m[ram_addr_t'(a - RAM0_BASE)];
		end else if (ai >= int'(RAM1_BASE) && ai < int'(RAM1_BASE) + RAM_DEPTH) begin
			if (w)
				ram1_m[ram_addr_t'(a - RAM1_BASE)] = d;
			r = ram1_m[ram_addr_t'(a - RAM1_BASE)];
		end else if (w && ai < int'(CTRL_BASE) + CTRL_SPAN && !flags_m[1]) begin
			flags_m[4:1] = {d[CTRL_MARIA_EN], d[CTRL_BIOS_EN], d[CTRL_TIA_EN], d[CTRL_LOCK]};
			if (writes_m < 2)
				writes_m++;
			flags_m[0] = (writes_m == 2);
		end
		if (w)
			r = d;
		open_m = r;
		return r;
	endfunction

	task automatic model_reset(input logic bypass, input logic tia);
		open_m = '0;
		flags_m = bypass ? {~tia, 1'b1, tia, tia, 1'b1} : 5'b0;
		writes_m = bypass ? 2 : 0;
	endtask

	task automatic report_mismatch(input string name, input logic [7:0] e, input logic [7:0] a);
		errors++;
		$display("[ERROR] %s: expected %h, actual %h", name, e, a);
	endtask

	task automatic end_run();
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, DUT.handshake_chk.fail_count);
		if (errors == 0 && DUT.handshake_chk.fail_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	endtask

	task automatic fail_timeout(input string what);
		errors++;
		$display("Timeout waiting for %s", what);
		timed_out = 1'b1;
		forever @(posedge clk_sys);   // Stimulus halts here
	endtask

	task automatic apply_reset(input logic bypass, input logic tia);
		@(posedge clk_sys);
		reset <= 1'b1;
		bypass_bios <= bypass;
		tia_mode <= tia;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
		repeat (2) @(posedge clk_sys);   // Past the preset cycle
		model_reset(bypass, tia);
	endtask

	// One four-phase host transaction
	task automatic host_xfer(input string name, input addr_t a, input logic w, input data_t d,
		input int ack_limit);
		int n;
		exp_rd = model_access(a, w, d);
		exp_flags = flags_m;
		chk_read = !w;
		chk_name = name;
		@(posedge clk_sys);
		addr <= a;
		we <= w;
		wdata <= d;
		req <= 1'b1;
		n = 0;
		while (!ack && n < ack_limit) begin
			@(posedge clk_sys);
			n++;
		end
		if (!ack)
			fail_timeout({name, " ack to rise"});
		req <= 1'b0;
		n = 0;
		while (ack && n < 64) begin
			@(posedge clk_sys);
			n++;
		end
		if (ack)
			fail_timeout({name, " ack to fall"});
	endtask

	// Run ends here after a stalled handshake
	initial begin
		wait (timed_out);
		end_run();
	end

	////////////////////
	// Comparison
	////////////////////

	always @(posedge clk_sys) begin
		ack_d <= ack;
		if (ack && !ack_d) begin
			checks++;
			if (clear_busy) begin
				errors++;
				$display("Host ack came back while the RAM clear pass was still running");
			end
			if (chk_read && rdata !== exp_rd)
				report_mismatch(chk_name, exp_rd, rdata);
			if (flags_dut !== exp_flags)
				report_mismatch({chk_name, "_flags"}, {3'b0, exp_flags}, {3'b0, flags_dut});
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		ram_addr_t off [16];
		data_t d0, d1, cv, hd;
		addr_t ha;
		int n;
		reset = 1'b1;
		req = 1'b0;
		addr = '0;
		we = 1'b0;
		wdata = '0;
		loading = 1'b0;
		clearval = '0;
		bypass_bios = 1'b0;
		tia_mode = 1'b0;

		apply_reset(1'b0, 1'b0);
		checks++;
		if ({ack, clear_busy} !== 2'b00 || flags_dut !== flags_m)
			report_mismatch("reset_state", {1'b0, 2'b00, flags_m},
				{1'b0, ack, clear_busy, flags_dut});

		// Same offsets in both banks, different data
		for (int i = 0; i < 16; i++) begin
			off[i] = ram_addr_t'(rand_bits(11));
			d0 = data_t'(rand_bits(8));
			d1 = data_t'(rand_bits(8));
			if (d1 == d0)
				d1 = ~d0;
			host_xfer("ram0_write", RAM0_BASE + addr_t'(off[i]), 1'b1, d0, 64);
			host_xfer("ram1_write", RAM1_BASE + addr_t'(off[i]), 1'b1, d1, 64);
		end
		for (int i = 0; i < 16; i++) begin
			host_xfer("ram0_read", RAM0_BASE + addr_t'(off[i]), 1'b0, '0, 64);
			host_xfer("ram1_read", RAM1_BASE + addr_t'(off[i]), 1'b0, '0, 64);
		end

		host_xfer("open_bus_high", 16'h8000 | addr_t'(rand_bits(15)), 1'b0, '0, 64);
		host_xfer("open_bus_ctrl", CTRL_BASE + addr_t'(rand_bits(5)), 1'b0, '0, 64);
		host_xfer("open_bus_fill", RAM1_BASE + 16'h0123, 1'b1, data_t'(rand_bits(8)), 64);
		host_xfer("open_bus_gap", 16'h0400, 1'b0, '0, 64);

		host_xfer("ctrl_first", CTRL_BASE + addr_t'(rand_bits(5)), 1'b1, 8'h06, 64);
		host_xfer("ctrl_second", CTRL_BASE + addr_t'(rand_bits(5)), 1'b1, 8'h08, 64);
		host_xfer("ctrl_lock", CTRL_BASE + addr_t'(rand_bits(5)), 1'b1, 8'h03, 64);
		host_xfer("ctrl_locked", CTRL_BASE + addr_t'(rand_bits(5)), 1'b1, 8'h0c, 64);

		// RAM clear with a host write queued behind it
		cv = data_t'(rand_bits(8));
		hd = data_t'(rand_bits(8));
		if (hd == cv)
			hd = ~cv;
		ha = RAM1_BASE + addr_t'(rand_bits(11));
		for (int i = 0; i < RAM_DEPTH; i++) begin
			void'(model_access(RAM0_BASE + addr_t'(i), 1'b1, cv));
			void'(model_access(RAM1_BASE + addr_t'(i), 1'b1, cv));
		end
		@(posedge clk_sys);
		loading <= 1'b1;
		clearval <= cv;
		n = 0;
		while (!clear_busy && n < 64) begin
			@(posedge clk_sys);
			n++;
		end
		if (!clear_busy)
			fail_timeout("clear_busy to rise");
		loading <= 1'b0;
		host_xfer("clear_host_write", ha, 1'b1, hd, 40000);
		checks++;
		if (clear_busy !== 1'b0)
			report_mismatch("clear_busy_after", 8'h00, {7'b0, clear_busy});
		for (int i = 0; i < 24; i++) begin
			host_xfer("clear_ram0_read", RAM0_BASE + addr_t'(rand_bits(11)), 1'b0, '0, 64);
			host_xfer("clear_ram1_read", RAM1_BASE + addr_t'(rand_bits(11)), 1'b0, '0, 64);
		end
		host_xfer("clear_host_word", ha, 1'b0, '0, 64);

		apply_reset(1'b1, 1'b1);
		checks++;
		if (flags_dut !== flags_m)
			report_mismatch("bypass_preset", {3'b0, flags_m}, {3'b0, flags_dut});
		host_xfer("bypass_write", CTRL_BASE + addr_t'(rand_bits(5)), 1'b1, 8'h06, 64);

		end_run();
	end

endmodule

//--- src.f
source/bus_pkg.sv
source/ctrl_pkg.sv
source/mem_bus_if.sv
source/work_ram.sv
source/inputctrl_reg.sv
source/bus_decoder.sv
source/ram_clear.sv
source/bus_arbiter.sv
source/console_bus.sv
bench/console_bus_assert.sv
bench/tb_console_bus.sv
